/* logic/mix_pkg.sv */
//**************************************************************************
// mix_pkg
// Widths, limits and packed types shared by the FM channel output mixer
//**************************************************************************
`default_nettype none

package mix_pkg;

    localparam int NUM_BANKS      = 2;
    localparam int CHANS_PER_BANK = 9;
    localparam int OPS_PER_BANK   = 18;
    localparam int NUM_STEPS      = 18;     // one step per (bank, channel)
    localparam int FOUR_OP_PAIRS  = 3;      // heads are channels 0..2 of a bank
    localparam int NUM_LANES      = 4;      // output lanes a..d

    localparam int OP_WIDTH    = 13;
    localparam int VOICE_WIDTH = 15;        // room for three operators
    localparam int ACC_WIDTH   = 20;        // room for eighteen voices
    localparam int OUT_WIDTH   = 16;

    localparam int signed OUT_MAX = 32767;
    localparam int signed OUT_MIN = -32768;

    localparam int FRAME_LATENCY = 20;      // start strobe to sample_valid

    typedef logic signed [OP_WIDTH-1:0] op_sample_t;

    typedef op_sample_t [OPS_PER_BANK-1:0] op_bank_t;
    typedef op_bank_t [NUM_BANKS-1:0] op_frame_t;    // 468 bits

    // one enable per output lane
    typedef struct packed {
        logic a;
        logic b;
        logic c;
        logic d;
    } lane_route_t;

    typedef struct packed {
        logic        cnt;                   // 1 = additive
        lane_route_t route;
    } chan_cfg_t;

    typedef chan_cfg_t [CHANS_PER_BANK-1:0] bank_cfg_t;
    typedef bank_cfg_t [NUM_BANKS-1:0] cfg_frame_t;  // 90 bits

    typedef struct packed {
        logic       valid;
        logic       bank;
        logic [3:0] chan;
        logic       last;                   // final step of the frame
    } step_t;

    typedef struct packed {
        logic                          valid;
        logic                          last;
        logic signed [VOICE_WIDTH-1:0] sample;
        lane_route_t                   route;
    } voice_t;

    typedef struct packed {
        logic signed [OUT_WIDTH-1:0] a;
        logic signed [OUT_WIDTH-1:0] b;
        logic signed [OUT_WIDTH-1:0] c;
        logic signed [OUT_WIDTH-1:0] d;
    } mix_out_t;

endpackage

`default_nettype wire

/* logic/mix_control.sv */
//**************************************************************************
// mix_control
// Frame sequencer, walks bank 0 then bank 1 channels 0..8, one per cycle
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module mix_control
    import mix_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    output step_t step
);

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t     state;
    logic       bank;
    logic [3:0] chan;
    logic       chan_end;

    assign chan_end = (chan == 4'(CHANS_PER_BANK - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            bank  <= 1'b0;
            chan  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin            // start while running is dropped
                        state <= RUN;
                        bank  <= 1'b0;
                        chan  <= '0;
                    end
                end
                RUN: begin
                    if (chan_end) begin
                        chan <= '0;
                        bank <= ~bank;          // wraps back to bank 0
                        if (bank) begin
                            state <= IDLE;
                        end
                    end else begin
                        chan <= chan + 4'd1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign step = '{
        valid: (state == RUN),
        bank:  bank,
        chan:  chan,
        last:  (state == RUN) && bank && chan_end
    };

    chan_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        step.valid |-> (step.chan <= 4'(CHANS_PER_BANK - 1))
    );

    // the frame ends on its last step
    idle_after_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        step.last |=> !step.valid
    );

endmodule

`default_nettype wire

/* logic/voice_combiner.sv */
//**************************************************************************
// voice_combiner
// Builds the voice of the stepped channel from its operators, by two-op,
// four-op or percussion connection, and registers it with its routing
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module voice_combiner
    import mix_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  step_t      step,
    input  op_frame_t  op_in,
    input  cfg_frame_t cfg,
    input  logic [5:0] four_op_sel,
    input  logic       rhythm_en,
    output voice_t     voice
);

    op_bank_t                      ops;
    bank_cfg_t                     bank_cfg;
    chan_cfg_t                     chan_cfg;
    chan_cfg_t                     pair_cfg;     // channel c+3 of a head
    logic [FOUR_OP_PAIRS-1:0]      bank_sel;
    logic [4:0]                    base;         // modulator op of the channel
    logic [1:0]                    head;
    logic                          is_head;
    logic                          is_partner;
    logic                          is_perc;
    logic signed [VOICE_WIDTH-1:0] op_0;
    logic signed [VOICE_WIDTH-1:0] op_3;
    logic signed [VOICE_WIDTH-1:0] op_6;
    logic signed [VOICE_WIDTH-1:0] op_9;
    logic signed [VOICE_WIDTH-1:0] sample_d;
    lane_route_t                   route_d;
    logic                          valid_q;
    logic                          last_q;
    logic signed [VOICE_WIDTH-1:0] sample_q;
    lane_route_t                   route_q;

    assign ops      = op_in[step.bank];
    assign bank_cfg = cfg[step.bank];
    assign chan_cfg = bank_cfg[step.chan];
    assign head     = step.chan[1:0];
    assign pair_cfg = bank_cfg[4'(head) + 4'd3];
    assign bank_sel = four_op_sel[step.bank * FOUR_OP_PAIRS +: FOUR_OP_PAIRS];

    // b = c + 3 * (c / 3)
    always_comb begin
        if (step.chan < 4'd3)
            base = 5'(step.chan);
        else if (step.chan < 4'd6)
            base = 5'(step.chan) + 5'd3;
        else
            base = 5'(step.chan) + 5'd6;
    end

    assign op_0 = $signed(ops[base]);
    assign op_3 = $signed(ops[base + 5'd3]);
    assign op_6 = $signed(ops[5'(head) + 5'd6]);  // only heads read these two
    assign op_9 = $signed(ops[5'(head) + 5'd9]);

    always_comb begin
        is_head    = 1'b0;
        is_partner = 1'b0;
        for (int p = 0; p < FOUR_OP_PAIRS; p++) begin
            if (step.chan == 4'(p))
                is_head = bank_sel[p];
            if (step.chan == 4'(p + FOUR_OP_PAIRS))
                is_partner = bank_sel[p];
        end
    end

    assign is_perc = rhythm_en && !step.bank && (step.chan >= 4'd6);

    always_comb begin
        sample_d = op_3;                         // serial two-op, carrier only
        route_d  = chan_cfg.route;
        if (is_head) begin
            case ({chan_cfg.cnt, pair_cfg.cnt})
                2'b00:   sample_d = op_9;
                2'b01:   sample_d = op_3 + op_9;
                2'b10:   sample_d = op_0 + op_9;
                default: sample_d = op_0 + op_6 + op_9;
            endcase
        end else if (is_partner) begin
            sample_d = '0;                       // partner is absorbed by its head
            route_d  = '0;
        end else if (is_perc) begin
            if (step.chan == 4'd6)
                sample_d = chan_cfg.cnt ? op_3 : op_0;   // bass drum
            else
                sample_d = op_0 + op_3;          // hh/sd and tom/cym
        end else if (chan_cfg.cnt) begin
            sample_d = op_0 + op_3;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= step.valid;
            last_q  <= step.last;
        end
    end

    always_ff @(posedge clk) begin
        sample_q <= sample_d;
        route_q  <= route_d;
    end

    assign voice = '{valid: valid_q, last: last_q, sample: sample_q, route: route_q};

    // voices of a frame arrive back to back up to the last
    voices_back_to_back: assert property (
        @(posedge clk) disable iff (!rst_n)
        voice.valid && !voice.last |=> voice.valid
    );

endmodule

`default_nettype wire

/* logic/output_mixer.sv */
//**************************************************************************
// output_mixer
// Four lane accumulators, saturated to 16 bits into the output register
// on the last voice of each frame
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module output_mixer
    import mix_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  voice_t   voice,
    output mix_out_t mix_out,
    output logic     sample_valid
);

    logic signed [VOICE_WIDTH-1:0]          voice_sample;
    logic [NUM_LANES-1:0]                   lane_en;     // [3] = a .. [0] = d
    logic signed [ACC_WIDTH-1:0]            acc_q [NUM_LANES];
    logic signed [ACC_WIDTH-1:0]            acc_next [NUM_LANES];
    logic [NUM_LANES-1:0][OUT_WIDTH-1:0]    lanes_q;
    logic                                   valid_q;

    function automatic logic [OUT_WIDTH-1:0] saturate(
        input logic signed [ACC_WIDTH-1:0] value
    );
        if (value > OUT_MAX)
            return OUT_WIDTH'(OUT_MAX);
        else if (value < OUT_MIN)
            return OUT_WIDTH'(OUT_MIN);
        else
            return OUT_WIDTH'(value);
    endfunction

    assign voice_sample = voice.sample;
    assign lane_en      = voice.route;

    // running sum including the voice of this cycle
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            acc_next[l] = acc_q[l];
            if (voice.valid && lane_en[l])
                acc_next[l] = acc_q[l] + ACC_WIDTH'(voice_sample);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q   <= '{default: '0};
            lanes_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (voice.valid && voice.last) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    lanes_q[l] <= saturate(acc_next[l]);
                    acc_q[l]   <= '0;            // ready for the next frame
                end
                valid_q <= 1'b1;
            end else begin
                acc_q <= acc_next;
            end
        end
    end

    assign mix_out      = mix_out_t'(lanes_q);
    assign sample_valid = valid_q;

    // one strobe per frame, frames are at least eighteen cycles apart
    single_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid
    );

endmodule

`default_nettype wire

/* logic/channel_mixer_top.sv */
//**************************************************************************
// channel_mixer_top
// FM channel output mixer, sequencer, voice combiner and lane mixer
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module channel_mixer_top
    import mix_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,          // one frame per strobe
    input  op_frame_t  op_in,
    input  cfg_frame_t cfg,
    input  logic [5:0] four_op_sel,
    input  logic       rhythm_en,
    output mix_out_t   mix_out,
    output logic       sample_valid
);

    step_t  step;
    voice_t voice;

    mix_control u_mix_control (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .step  (step)
    );

    voice_combiner u_voice_combiner (
        .clk         (clk),
        .rst_n       (rst_n),
        .step        (step),
        .op_in       (op_in),
        .cfg         (cfg),
        .four_op_sel (four_op_sel),
        .rhythm_en   (rhythm_en),
        .voice       (voice)
    );

    output_mixer u_output_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .voice        (voice),
        .mix_out      (mix_out),
        .sample_valid (sample_valid)
    );

    // a frame starts only from idle, so its last step leads its strobe by two
    last_to_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        step.last |-> ##2 sample_valid
    );

endmodule

`default_nettype wire

/* sim/tb_channel_mixer.sv */
//**************************************************************************
// tb_channel_mixer
// Testbench for the FM channel output mixer, table driven frames checked
// against a reference model of the connection rules
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_channel_mixer
    import mix_pkg::*;
();

    localparam int NUM_ROWS = 13;
    localparam int WAIT_MAX = FRAME_LATENCY + 10;

    localparam logic [1:0] ROUTE_ALL    = 2'd0;
    localparam logic [1:0] ROUTE_ONEHOT = 2'd1;    // lane by voice index mod 4
    localparam logic [1:0] ROUTE_SUBSET = 2'd2;    // non-empty subset per voice
    localparam logic [1:0] ROUTE_RANDOM = 2'd3;

    typedef struct packed {
        logic [5:0]  four_op_sel;
        logic        rhythm_en;
        logic [17:0] cnt_mask;                     // bit bank*9+chan
        logic        cnt_rand;
        logic [1:0]  route_mode;
        logic        op_rand;                      // random ops, model gives lanes
        logic [12:0] op_val;
        logic        extra_start;                  // second strobe mid-frame
        logic [15:0] exp_a;
        logic [15:0] exp_b;
        logic [15:0] exp_c;
        logic [15:0] exp_d;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    op_frame_t   op_in;
    cfg_frame_t  cfg;
    logic [5:0]  four_op_sel;
    logic        rhythm_en;
    mix_out_t    mix_out;
    logic        sample_valid;

    logic [31:0] lfsr_state;
    row_t        rows [NUM_ROWS];

    channel_mixer_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .op_in        (op_in),
        .cfg          (cfg),
        .four_op_sel  (four_op_sel),
        .rhythm_en    (rhythm_en),
        .mix_out      (mix_out),
        .sample_valid (sample_valid)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        else
            return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
    endtask

    function automatic int op_value(input op_frame_t ops, input int bk, input int idx);
        logic [OP_WIDTH-1:0] raw;
        raw = ops[bk][idx];
        return {{(32 - OP_WIDTH){raw[OP_WIDTH-1]}}, raw};
    endfunction

    function automatic logic [15:0] clamp16(input int s);
        if (s > 32767)
            return 16'h7FFF;
        if (s < -32768)
            return 16'h8000;
        return s[15:0];
    endfunction

    // lanes from the channel connection rules
    function automatic mix_out_t model_mix(input op_frame_t ops, input cfg_frame_t cf,
                                           input logic [5:0] sel, input logic rhy);
        int        sum [NUM_LANES];
        int        v;
        int        b;
        chan_cfg_t cc;
        chan_cfg_t pc;
        logic      head;
        logic      partner;
        mix_out_t  res;
        for (int l = 0; l < NUM_LANES; l++)
            sum[l] = 0;
        for (int bk = 0; bk < NUM_BANKS; bk++) begin
            for (int c = 0; c < CHANS_PER_BANK; c++) begin
                cc      = cf[bk][c];
                b       = c + 3 * (c / 3);
                head    = 1'b0;
                partner = 1'b0;
                if (c < 3)
                    head = sel[bk * 3 + c];
                else if (c < 6)
                    partner = sel[bk * 3 + c - 3];
                if (partner) begin
                    v = 0;
                end else if (head) begin
                    pc = cf[bk][c + 3];
                    case ({cc.cnt, pc.cnt})
                        2'b00:   v = op_value(ops, bk, b + 9);
                        2'b01:   v = op_value(ops, bk, b + 3) + op_value(ops, bk, b + 9);
                        2'b10:   v = op_value(ops, bk, b) + op_value(ops, bk, b + 9);
                        default: v = op_value(ops, bk, b) + op_value(ops, bk, b + 6)
                                     + op_value(ops, bk, b + 9);
                    endcase
                end else if (rhy && bk == 0 && c == 6) begin
                    v = cc.cnt ? op_value(ops, 0, 15) : op_value(ops, 0, 12);
                end else if ((rhy && bk == 0 && c > 6) || cc.cnt) begin
                    v = op_value(ops, bk, b) + op_value(ops, bk, b + 3);
                end else begin
                    v = op_value(ops, bk, b + 3);
                end
                if (cc.route.a) sum[0] += v;
                if (cc.route.b) sum[1] += v;
                if (cc.route.c) sum[2] += v;
                if (cc.route.d) sum[3] += v;
            end
        end
        res.a = clamp16(sum[0]);
        res.b = clamp16(sum[1]);
        res.c = clamp16(sum[2]);
        res.d = clamp16(sum[3]);
        return res;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h",
                                name, got, expected));
        end
    endtask

    task automatic check_lanes(input mix_out_t expected);
        compare_value("mix_out.a", {16'h0000, mix_out.a}, {16'h0000, expected.a});
        compare_value("mix_out.b", {16'h0000, mix_out.b}, {16'h0000, expected.b});
        compare_value("mix_out.c", {16'h0000, mix_out.c}, {16'h0000, expected.c});
        compare_value("mix_out.d", {16'h0000, mix_out.d}, {16'h0000, expected.d});
    endtask

    task automatic run_frame(input int n);
        row_t        r;
        mix_out_t    expected;
        int          cycles;
        int          idx;
        logic [31:0] bits;
        chan_cfg_t   cc;
        r = rows[n];
        for (int bk = 0; bk < NUM_BANKS; bk++) begin
            for (int o = 0; o < OPS_PER_BANK; o++) begin
                if (r.op_rand) begin
                    take_bits(OP_WIDTH, bits);
                    op_in[bk][o] = bits[OP_WIDTH-1:0];
                end else begin
                    op_in[bk][o] = r.op_val;
                end
            end
            for (int c = 0; c < CHANS_PER_BANK; c++) begin
                idx = bk * CHANS_PER_BANK + c;
                if (r.cnt_rand) begin
                    take_bits(1, bits);
                    cc.cnt = bits[0];
                end else begin
                    cc.cnt = r.cnt_mask[idx];
                end
                case (r.route_mode)
                    ROUTE_ALL:    cc.route = lane_route_t'(4'hF);
                    ROUTE_ONEHOT: cc.route = lane_route_t'(4'b1000 >> (idx % 4));
                    ROUTE_SUBSET: cc.route = lane_route_t'(4'(idx % 15 + 1));
                    default: begin
                        take_bits(4, bits);
                        cc.route = lane_route_t'(bits[3:0]);
                    end
                endcase
                cfg[bk][c] = cc;
            end
        end
        four_op_sel = r.four_op_sel;
        rhythm_en   = r.rhythm_en;
        if (r.op_rand)
            expected = model_mix(op_in, cfg, four_op_sel, rhythm_en);
        else
            expected = mix_out_t'({r.exp_a, r.exp_b, r.exp_c, r.exp_d});
        start  = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            start = r.extra_start && (cycles == 6);   // must be ignored
            if (cycles > WAIT_MAX)
                abort_run($sformatf("timeout: no sample_valid for frame of row %0d", n));
        end while (!sample_valid);
        compare_value("latency", cycles, FRAME_LATENCY);
        check_lanes(expected);
        for (int k = 0; k < FRAME_LATENCY + 2; k++) begin
            @(posedge clk);
            #1;
            compare_value("sample_valid", {31'd0, sample_valid}, 32'd0);
        end
        check_lanes(expected);                         // output holds between frames
    endtask

    task automatic fill_rows();
        rows[0]  = '{6'h00, 1'b0, 18'h00000, 1'b0, ROUTE_ALL, 1'b0, 13'd100, 1'b0,
                     16'h0708, 16'h0708, 16'h0708, 16'h0708};     // serial two-op
        rows[1]  = '{6'h00, 1'b0, 18'h3FFFF, 1'b0, ROUTE_ONEHOT, 1'b0, 13'd10, 1'b0,
                     16'h0064, 16'h0064, 16'h0050, 16'h0050};     // additive, one lane each
        rows[2]  = '{6'h3F, 1'b0, 18'h3DA14, 1'b0, ROUTE_ALL, 1'b0, 13'd100, 1'b0,
                     16'h0834, 16'h0834, 16'h0834, 16'h0834};     // all heads, 4 cnt pairs
        rows[3]  = '{6'h00, 1'b1, 18'h00040, 1'b0, ROUTE_ALL, 1'b0, 13'd100, 1'b0,
                     16'h07D0, 16'h07D0, 16'h07D0, 16'h07D0};     // percussion
        rows[4]  = '{6'h00, 1'b0, 18'h3FFFF, 1'b0, ROUTE_ALL, 1'b0, 13'h0FFF, 1'b0,
                     16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF};     // +4095 clamps
        rows[5]  = '{6'h00, 1'b0, 18'h3FFFF, 1'b0, ROUTE_ALL, 1'b0, 13'h1000, 1'b0,
                     16'h8000, 16'h8000, 16'h8000, 16'h8000};     // -4096 clamps
        rows[6]  = '{6'h00, 1'b0, 18'h0, 1'b1, ROUTE_SUBSET, 1'b1, 13'd0, 1'b0,
                     16'h0, 16'h0, 16'h0, 16'h0};
        rows[7]  = '{6'h00, 1'b0, 18'h0, 1'b1, ROUTE_RANDOM, 1'b1, 13'd0, 1'b0,
                     16'h0, 16'h0, 16'h0, 16'h0};
        rows[8]  = '{6'h2D, 1'b0, 18'h0, 1'b1, ROUTE_RANDOM, 1'b1, 13'd0, 1'b0,
                     16'h0, 16'h0, 16'h0, 16'h0};
        rows[9]  = '{6'h3F, 1'b1, 18'h0, 1'b1, ROUTE_RANDOM, 1'b1, 13'd0, 1'b0,
                     16'h0, 16'h0, 16'h0, 16'h0};
        rows[10] = '{6'h00, 1'b1, 18'h0, 1'b1, ROUTE_SUBSET, 1'b1, 13'd0, 1'b0,
                     16'h0, 16'h0, 16'h0, 16'h0};
        rows[11] = '{6'h00, 1'b0, 18'h3FFFF, 1'b0, ROUTE_ONEHOT, 1'b0, 13'd10, 1'b1,
                     16'h0064, 16'h0064, 16'h0050, 16'h0050};     // start during frame
        rows[12] = '{6'h12, 1'b1, 18'h0, 1'b1, ROUTE_RANDOM, 1'b1, 13'd0, 1'b1,
                     16'h0, 16'h0, 16'h0, 16'h0};
    endtask

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        op_in       = '0;
        cfg         = '0;
        four_op_sel = '0;
        rhythm_en   = 1'b0;
        lfsr_state  = 32'h8d7b66f7;
        fill_rows();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int k = 0; k < 3; k++) begin                // idle, nothing started yet
            @(posedge clk);
            #1;
            compare_value("sample_valid", {31'd0, sample_valid}, 32'd0);
            check_lanes('0);
        end
        for (int n = 0; n < NUM_ROWS; n++)
            run_frame(n);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/mix_pkg.sv
logic/mix_control.sv
logic/voice_combiner.sv
logic/output_mixer.sv
logic/channel_mixer_top.sv
sim/tb_channel_mixer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the channel mixer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_channel_mixer \
    --Mdir obj_dir \
    -o tb_channel_mixer \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_channel_mixer)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
